// File: run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_cache_top -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

# the simulator output is kept in a variable, never in a log file
sim_output=$(./obj_dir/Vtb_cache_top 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx 'Finished with no errors' <<< "$sim_output"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim.f
src/cache_pkg.sv
src/cache_way.sv
src/lru_array.sv
src/cache_datapath.sv
src/mem_gap_timer.sv
src/cache_control.sv
src/cache_top.sv
tb/mem_responder.sv
tb/tb_cache_top.sv

// File: src/cache_control.sv
`timescale 1ns/100ps
`default_nettype none

module cache_control (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cpu_req,
	input  logic                    cpu_we,
	input  logic                    mem_ack,
	input  logic                    gap_done,
	input  logic                    hit0,
	input  logic                    hit1,
	input  logic                    lru_out,
	input  logic                    dir0_out,
	input  logic                    dir1_out,
	output logic                    cpu_ack,
	output logic                    mem_req,
	output logic                    mem_we,
	output logic                    write0,
	output logic                    write1,
	output logic                    val_in,
	output logic                    dir_in,
	output logic                    indata_sel,
	output logic                    outdata_sel,
	output cache_pkg::memaddr_sel_t memaddr_sel,
	output logic                    lru_we,
	output logic                    lru_in
);

	cache_pkg::cache_state_t state, next_state;

	logic hit;          // the two ways never match together since a fill only replaces the victim
	logic victim_dirty; // the lru way holds a word that memory has not seen yet

	assign hit = hit0 | hit1;
	assign victim_dirty = lru_out ? dir1_out : dir0_out; // dirty implies valid

	// datapath controls and memory handshake, decoded from the current state
	always_comb
	begin
		mem_req = 1'b0;
		mem_we = 1'b0;
		write0 = 1'b0;
		write1 = 1'b0;
		val_in = 1'b0;
		dir_in = 1'b0;
		indata_sel = 1'b0; // memory read data unless a cpu write hits
		outdata_sel = 1'b0;
		memaddr_sel = cache_pkg::addr_cpu;
		lru_we = 1'b0;
		lru_in = 1'b0;

		case (state)
			cache_pkg::idle_lookup:
			begin
				if (cpu_req && hit)
				begin
					outdata_sel = hit1; // read word comes from the matching way
					if (cpu_we)
					begin
						// a write hit marks the line modified so it gets written back later
						write0 = hit0;
						write1 = hit1;
						val_in = 1'b1;
						dir_in = 1'b1;
						indata_sel = 1'b1;
					end
					lru_we = 1'b1;
					lru_in = hit0; // the way not touched becomes the next victim
				end
			end
			cache_pkg::store_data:
			begin
				outdata_sel = lru_out; // victim word goes out as mem_wdata
				memaddr_sel = lru_out ? cache_pkg::addr_way1 : cache_pkg::addr_way0;
				mem_we = 1'b1;
				mem_req = gap_done; // once up, gap_done stays high until this req falls
			end
			cache_pkg::load_data:
			begin
				memaddr_sel = cache_pkg::addr_cpu;
				mem_req = gap_done;
				if (mem_ack)
				begin
					// the fill lands in the victim on the edge that sees mem_ack, rdata is valid then
					write0 = ~lru_out;
					write1 = lru_out;
					val_in = 1'b1;
					dir_in = 1'b0; // fresh copy matches memory
				end
			end
			default:
			begin
				// release states only wait on the far side of a handshake
			end
		endcase
	end

	always_comb
	begin
		next_state = state;

		case (state)
			cache_pkg::idle_lookup:
			begin
				if (cpu_req)
				begin
					if (hit)
						next_state = cache_pkg::resp_release;
					else if (victim_dirty)
						next_state = cache_pkg::store_data;
					else
						next_state = cache_pkg::load_data;
				end
			end
			cache_pkg::store_data:
			begin
				if (mem_ack)
					next_state = cache_pkg::store_release;
			end
			cache_pkg::store_release:
			begin
				if (!mem_ack)
					next_state = cache_pkg::load_data; // fill still waits for the gap timer
			end
			cache_pkg::load_data:
			begin
				if (mem_ack)
					next_state = cache_pkg::load_release;
			end
			cache_pkg::load_release:
			begin
				if (!mem_ack)
					next_state = cache_pkg::idle_lookup; // the lookup now hits and answers the cpu
			end
			cache_pkg::resp_release:
			begin
				if (!cpu_req)
					next_state = cache_pkg::idle_lookup;
			end
			default:
			begin
				next_state = cache_pkg::idle_lookup;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cache_pkg::idle_lookup;
			cpu_ack <= 1'b0;
		end
		else
		begin
			state <= next_state;
			cpu_ack <= (next_state == cache_pkg::resp_release); // high for exactly the response phase
		end
	end

endmodule : cache_control

`default_nettype wire

// File: src/cache_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cache_datapath #(
	parameter  int INDEX_BITS = 3,
	localparam int TAG_BITS = cache_pkg::ADDR_BITS - INDEX_BITS
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [cache_pkg::ADDR_BITS-1:0] cpu_addr,
	input  logic [cache_pkg::DATA_BITS-1:0] cpu_wdata,
	input  logic [cache_pkg::DATA_BITS-1:0] mem_rdata,
	input  logic                            write0,
	input  logic                            write1,
	input  logic                            val_in,
	input  logic                            dir_in,
	input  logic                            indata_sel,
	input  logic                            outdata_sel,
	input  cache_pkg::memaddr_sel_t         memaddr_sel,
	input  logic                            lru_we,
	input  logic                            lru_in,
	input  logic                            cpu_ack,
	output logic                            hit0,
	output logic                            hit1,
	output logic                            lru_out,
	output logic                            dir0_out,
	output logic                            dir1_out,
	output logic [cache_pkg::DATA_BITS-1:0] cpu_rdata,
	output logic [cache_pkg::ADDR_BITS-1:0] mem_addr,
	output logic [cache_pkg::DATA_BITS-1:0] mem_wdata
);

	logic [INDEX_BITS-1:0]           index;
	logic [TAG_BITS-1:0]             tag;
	logic [TAG_BITS-1:0]             tag0_out, tag1_out;
	logic                            val0_out, val1_out;
	logic [cache_pkg::DATA_BITS-1:0] data0_out, data1_out;
	logic [cache_pkg::DATA_BITS-1:0] way_wdata; // shared write data for both ways
	logic [cache_pkg::DATA_BITS-1:0] out_word;

	assign index = cpu_addr[INDEX_BITS-1:0];
	assign tag = cpu_addr[cache_pkg::ADDR_BITS-1:INDEX_BITS];

	assign way_wdata = indata_sel ? cpu_wdata : mem_rdata; // cpu on write hits, memory on fills

	cache_way #(.INDEX_BITS(INDEX_BITS)) way0 (
		.clk(clk), .reset(reset), .index(index), .we(write0),
		.tag_in(tag), .val_in(val_in), .dir_in(dir_in), .data_in(way_wdata),
		.tag_out(tag0_out), .val_out(val0_out), .dir_out(dir0_out), .data_out(data0_out)
	);

	cache_way #(.INDEX_BITS(INDEX_BITS)) way1 (
		.clk(clk), .reset(reset), .index(index), .we(write1),
		.tag_in(tag), .val_in(val_in), .dir_in(dir_in), .data_in(way_wdata),
		.tag_out(tag1_out), .val_out(val1_out), .dir_out(dir1_out), .data_out(data1_out)
	);

	lru_array #(.INDEX_BITS(INDEX_BITS)) lru (
		.clk(clk), .reset(reset), .index(index), .we(lru_we), .lru_in(lru_in), .lru_out(lru_out)
	);

	assign hit0 = val0_out && (tag0_out == tag);
	assign hit1 = val1_out && (tag1_out == tag);

	// write-back addresses rebuild the victim's word address from its stored tag
	always_comb
	begin
		case (memaddr_sel)
			cache_pkg::addr_way0: mem_addr = {tag0_out, index};
			cache_pkg::addr_way1: mem_addr = {tag1_out, index};
			default:              mem_addr = cpu_addr;
		endcase
	end

	assign out_word = outdata_sel ? data1_out : data0_out;
	assign mem_wdata = out_word;

	// keeps sampling while ack is low, so the word seen on the rising edge of cpu_ack is held
	always_ff @(posedge clk)
	begin
		if (!cpu_ack)
			cpu_rdata <= out_word;
	end

endmodule : cache_datapath

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// cpu word address width; each line holds exactly one word
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32; // width of a cached data word

	// source of the address driven onto the memory port
	typedef enum logic [1:0] {
		addr_cpu  = 2'b00, // fill from the address the cpu asked for
		addr_way0 = 2'b01, // write-back of way 0, built from its stored tag
		addr_way1 = 2'b10  // write-back of way 1
	} memaddr_sel_t;

	// controller states, one transaction in flight at a time
	typedef enum logic [2:0] {
		idle_lookup,   // waits for cpu_req and checks both ways
		store_data,    // dirty victim goes out to memory
		store_release, // waits for mem_ack to drop after the write-back
		load_data,     // fill request at the cpu address
		load_release,  // waits for mem_ack to drop after the fill
		resp_release   // cpu_ack held high until the cpu drops cpu_req
	} cache_state_t;

endpackage : cache_pkg

`default_nettype wire

// File: src/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
	parameter int INDEX_BITS = 3, // eight sets by default
	parameter int GAP_CYCLES = 2  // idle cycles forced between memory requests
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cpu_req,
	input  logic                            cpu_we,
	input  logic [cache_pkg::ADDR_BITS-1:0] cpu_addr,
	input  logic [cache_pkg::DATA_BITS-1:0] cpu_wdata,
	output logic                            cpu_ack,
	output logic [cache_pkg::DATA_BITS-1:0] cpu_rdata,
	output logic                            mem_req,
	output logic                            mem_we,
	output logic [cache_pkg::ADDR_BITS-1:0] mem_addr,
	output logic [cache_pkg::DATA_BITS-1:0] mem_wdata,
	input  logic                            mem_ack,
	input  logic [cache_pkg::DATA_BITS-1:0] mem_rdata
);

	logic                    gap_done;
	logic                    hit0, hit1;
	logic                    lru_out, lru_we, lru_in;
	logic                    dir0_out, dir1_out;
	logic                    write0, write1;
	logic                    val_in, dir_in;
	logic                    indata_sel, outdata_sel;
	cache_pkg::memaddr_sel_t memaddr_sel;

	cache_control u_control (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_we(cpu_we),
		.mem_ack(mem_ack), .gap_done(gap_done), .hit0(hit0), .hit1(hit1),
		.lru_out(lru_out), .dir0_out(dir0_out), .dir1_out(dir1_out),
		.cpu_ack(cpu_ack), .mem_req(mem_req), .mem_we(mem_we),
		.write0(write0), .write1(write1), .val_in(val_in), .dir_in(dir_in),
		.indata_sel(indata_sel), .outdata_sel(outdata_sel), .memaddr_sel(memaddr_sel),
		.lru_we(lru_we), .lru_in(lru_in)
	);

	// watches the request line the controller drives and spaces consecutive accesses
	mem_gap_timer #(.GAP_CYCLES(GAP_CYCLES)) u_gap_timer (
		.clk(clk), .reset(reset), .mem_req(mem_req), .gap_done(gap_done)
	);

	cache_datapath #(.INDEX_BITS(INDEX_BITS)) u_datapath (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.mem_rdata(mem_rdata), .write0(write0), .write1(write1),
		.val_in(val_in), .dir_in(dir_in), .indata_sel(indata_sel),
		.outdata_sel(outdata_sel), .memaddr_sel(memaddr_sel),
		.lru_we(lru_we), .lru_in(lru_in), .cpu_ack(cpu_ack),
		.hit0(hit0), .hit1(hit1), .lru_out(lru_out),
		.dir0_out(dir0_out), .dir1_out(dir1_out), .cpu_rdata(cpu_rdata),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule : cache_top

`default_nettype wire

// File: src/cache_way.sv
`timescale 1ns/100ps
`default_nettype none

module cache_way #(
	parameter  int INDEX_BITS = 3,
	localparam int TAG_BITS = cache_pkg::ADDR_BITS - INDEX_BITS,
	localparam int SETS = 2 ** INDEX_BITS
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [INDEX_BITS-1:0]          index,
	input  logic                           we,
	input  logic [TAG_BITS-1:0]            tag_in,
	input  logic                           val_in,
	input  logic                           dir_in,
	input  logic [cache_pkg::DATA_BITS-1:0] data_in,
	output logic [TAG_BITS-1:0]            tag_out,
	output logic                           val_out,
	output logic                           dir_out,
	output logic [cache_pkg::DATA_BITS-1:0] data_out
);

	logic [TAG_BITS-1:0]             tag_mem [SETS];
	logic [cache_pkg::DATA_BITS-1:0] data_mem [SETS];
	logic [SETS-1:0]                 valid_bits; // one flag per set
	logic [SETS-1:0]                 dirty_bits;

	// status bits must come up empty so nothing hits or writes back garbage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (we)
		begin
			valid_bits[index] <= val_in;
			dirty_bits[index] <= dir_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			tag_mem[index] <= tag_in;
			data_mem[index] <= data_in;
		end
	end

	// reads are combinational so hit and dirty status are known in the same cycle
	assign tag_out = tag_mem[index];
	assign data_out = data_mem[index];
	assign val_out = valid_bits[index];
	assign dir_out = dirty_bits[index];

endmodule : cache_way

`default_nettype wire

// File: src/lru_array.sv
`timescale 1ns/100ps
`default_nettype none

module lru_array #(
	parameter  int INDEX_BITS = 3,
	localparam int SETS = 2 ** INDEX_BITS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [INDEX_BITS-1:0] index,
	input  logic                  we,
	input  logic                  lru_in,
	output logic                  lru_out
);

	logic [SETS-1:0] lru_bits; // 0 means way 0 is evicted next, 1 means way 1

	always_ff @(posedge clk)
	begin
		if (reset)
			lru_bits <= '0; // empty sets fill way 0 first
		else if (we)
			lru_bits[index] <= lru_in;
	end

	assign lru_out = lru_bits[index];

endmodule : lru_array

`default_nettype wire

// File: src/mem_gap_timer.sv
`timescale 1ns/100ps
`default_nettype none

module mem_gap_timer #(
	parameter int GAP_CYCLES = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic mem_req,
	output logic gap_done
);

	// enough bits to hold GAP_CYCLES, and never less than one
	localparam int CNT_BITS = (GAP_CYCLES < 2) ? 1 : $clog2(GAP_CYCLES + 1);

	logic [CNT_BITS-1:0] count; // idle cycles still owed before the next request
	logic                req_q; // mem_req one cycle late, for edge detection

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_q <= 1'b0;
			count <= '0; // no gap owed out of reset
		end
		else
		begin
			req_q <= mem_req;
			if (req_q && !mem_req)
				count <= CNT_BITS'(GAP_CYCLES); // request just ended, start the gap
			else if (count != '0)
				count <= count - CNT_BITS'(1);
		end
	end

	assign gap_done = (count == '0);

endmodule : mem_gap_timer

`default_nettype wire

// File: tb/mem_responder.sv
`timescale 1ns/100ps
`default_nettype none

module mem_responder #(
	parameter logic [31:0] SEED = 32'h0629_2c1d
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            mem_req,
	input  logic                            mem_we,
	input  logic [cache_pkg::ADDR_BITS-1:0] mem_addr,
	input  logic [cache_pkg::DATA_BITS-1:0] mem_wdata,
	output logic                            mem_ack,
	output logic [cache_pkg::DATA_BITS-1:0] mem_rdata
);

	logic [31:0] mem [logic [31:0]]; // only words written back by the cache are stored
	logic [31:0] rnd;                // delay generator state
	int          wait_left;          // cycles still to go before ack, 0 when no request is seen

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// untouched words read as a fixed pattern where every address bit matters
	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return init_word(addr);
	endfunction

	initial
	begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		rnd = SEED;
		wait_left = 0;
		forever
		begin
			@(posedge clk);
			#1; // outputs change a little after the edge the cache samples on
			if (reset)
			begin
				mem_ack = 1'b0;
				wait_left = 0;
			end
			else if (mem_ack)
			begin
				if (!mem_req)
					mem_ack = 1'b0; // last phase of the handshake
			end
			else if (mem_req)
			begin
				if (wait_left == 0)
				begin
					// a new request, ack comes 1 to 6 cycles from now
					rnd = xorshift32(rnd);
					wait_left = 1 + int'(rnd % 32'd6);
				end
				else
				begin
					wait_left = wait_left - 1;
					if (wait_left == 0)
					begin
						if (mem_we)
							mem[mem_addr] = mem_wdata; // write-back from the cache
						else
							mem_rdata = read_word(mem_addr); // held while ack is high
						mem_ack = 1'b1;
					end
				end
			end
		end
	end

endmodule : mem_responder

`default_nettype wire

// File: tb/tb_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_top;

	localparam int          TIMEOUT = 200;  // cycles allowed for one handshake phase
	localparam int          N_RANDOM = 200; // operations in the random mix
	localparam logic [31:0] SEED = 32'h0629_2c1d;

	logic        clk = 1'b0;
	logic        reset, cpu_req, cpu_we, cpu_ack;
	logic [31:0] cpu_addr, cpu_wdata, cpu_rdata;
	logic        mem_req, mem_we, mem_ack;
	logic [31:0] mem_addr, mem_wdata, mem_rdata;

	logic [31:0] ref_mem [logic [31:0]]; // what each written address should read back
	logic        log_we [$];              // one entry per memory request seen
	logic [31:0] log_addr [$];
	logic [31:0] log_data [$];
	int          log_mark;                // first log entry of the current test
	int          errors = 0;              // value checks
	int          proto_errors = 0;        // handshake checks in the monitor
	int          tests_run = 0;
	int          errors_at_start;
	string       test_name;
	logic        timed_out = 1'b0;        // set once a cpu handshake never completed

	logic        cpu_ack_q, cpu_req_q, mem_req_q, mem_ack_q, mem_we_q;
	logic [31:0] mem_addr_q, mem_wdata_q;

	always #2 clk = ~clk;

	cache_top DUT (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	mem_responder #(.SEED(SEED)) memory (
		.clk(clk), .reset(reset), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// same pattern the memory starts with
	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
	endfunction

	function automatic logic [31:0] expect_word(input logic [31:0] addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		return init_word(addr);
	endfunction

	// handshake checks, sampled mid-cycle where every signal has settled
	always @(negedge clk)
	begin
		if (reset)
			assert (!cpu_ack && !mem_req && !mem_we)
			else
			begin
				$display("cpu_ack, mem_req or mem_we is high while reset is applied");
				proto_errors++;
			end
		else
		begin
			assert (!(cpu_ack && !cpu_ack_q) || cpu_req_q)
			else
			begin
				$display("cpu_ack rose without a pending cpu_req");
				proto_errors++;
			end
			if (mem_req_q && !mem_ack_q) // request open and not answered yet
				assert (mem_req && mem_we == mem_we_q && mem_addr == mem_addr_q
					&& mem_wdata == mem_wdata_q)
				else
				begin
					$display("memory request dropped or changed before mem_ack");
					proto_errors++;
				end
			if (mem_req && !mem_req_q)
			begin
				assert (!mem_ack)
				else
				begin
					$display("mem_req rose while mem_ack was still high");
					proto_errors++;
				end
				log_we.push_back(mem_we);
				log_addr.push_back(mem_addr);
				log_data.push_back(mem_wdata);
			end
		end
		cpu_ack_q <= cpu_ack;
		cpu_req_q <= cpu_req;
		mem_req_q <= mem_req;
		mem_ack_q <= mem_ack;
		mem_we_q <= mem_we;
		mem_addr_q <= mem_addr;
		mem_wdata_q <= mem_wdata;
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (!timed_out)
			assert (actual === expected)
			else
			begin
				$display("MISMATCH %s %s expected %h actual %h", test_name, what,
					expected, actual);
				errors++;
			end
	endtask

	task automatic note_timeout(input string what);
		$display("%s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	// one full four-phase exchange on the cpu port, called and returning 1 ns after an edge
	task automatic cpu_access(input logic we, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		rdata = '0;
		if (timed_out)
			return;
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		n = 0;
		while (!cpu_ack && !timed_out)
		begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				note_timeout($sformatf(
					"timeout: no cpu_ack for address %h, controller state %0d",
					addr, DUT.u_control.state));
		end
		rdata = cpu_rdata; // registered on the edge where ack rose
		cpu_req = 1'b0;
		n = 0;
		while (cpu_ack && !timed_out)
		begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT)
				note_timeout($sformatf("timeout: cpu_ack stuck high for address %h", addr));
		end
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused_rdata;
		cpu_access(1'b1, addr, data, unused_rdata);
		ref_mem[addr] = data;
	endtask

	task automatic read_check(input string what, input logic [31:0] addr);
		logic [31:0] rdata;
		cpu_access(1'b0, addr, 32'd0, rdata);
		check_value(what, expect_word(addr), rdata);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors + proto_errors;
		log_mark = log_addr.size(); // traffic before this point belongs to earlier tests
	endtask

	task automatic end_test();
		int n;
		n = errors + proto_errors - errors_at_start;
		tests_run++;
		if (n == 0)
			$display("test %0d %s passed", tests_run, test_name);
		else
			$display("test %0d %s failed with %0d errors", tests_run, test_name, n);
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [7:0]  tag_sel;
		reset = 1'b1;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		rnd = SEED;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test("read miss");
		read_check("read miss data", 32'h0000_1003);
		check_value("read miss request count", 32'd1, log_addr.size() - log_mark);
		check_value("read miss mem_we", 32'd0, {31'd0, log_we[log_mark]});
		check_value("read miss mem_addr", 32'h0000_1003, log_addr[log_mark]);
		end_test();

		begin_test("read hit");
		read_check("read hit data", 32'h0000_1003);
		check_value("read hit request count", 32'd0, log_addr.size() - log_mark);
		end_test();

		begin_test("write hit");
		cpu_write(32'h0000_1003, 32'hcafe_0001);
		read_check("write hit data", 32'h0000_1003);
		check_value("write hit request count", 32'd0, log_addr.size() - log_mark);
		end_test();

		// A, B and C all land in set 5, so C evicts the older dirty A
		begin_test("dirty eviction");
		cpu_write(32'h0000_0105, 32'h1111_aaaa);
		cpu_write(32'h0000_0205, 32'h2222_bbbb);
		log_mark = log_addr.size();
		read_check("eviction read of C", 32'h0000_0305);
		check_value("eviction request count", 32'd2, log_addr.size() - log_mark);
		check_value("eviction first mem_we", 32'd1, {31'd0, log_we[log_mark]});
		check_value("eviction write-back addr", 32'h0000_0105, log_addr[log_mark]);
		check_value("eviction write-back data", 32'h1111_aaaa, log_data[log_mark]);
		check_value("eviction fill addr", 32'h0000_0305, log_addr[log_mark + 1]);
		read_check("eviction reread of A", 32'h0000_0105);
		end_test();

		// touching A makes B the older way in set 6
		begin_test("lru order");
		cpu_write(32'h0000_0106, 32'h3333_cccc);
		cpu_write(32'h0000_0206, 32'h4444_dddd);
		read_check("lru touch of A", 32'h0000_0106);
		log_mark = log_addr.size();
		read_check("lru read of C", 32'h0000_0306);
		check_value("lru first mem_we", 32'd1, {31'd0, log_we[log_mark]});
		check_value("lru write-back addr", 32'h0000_0206, log_addr[log_mark]);
		check_value("lru write-back data", 32'h4444_dddd, log_data[log_mark]);
		end_test();

		begin_test("random mix");
		for (int i = 0; i < N_RANDOM; i++)
		begin
			rnd = xorshift32(rnd);
			tag_sel = rnd[15:8] % 8'd6; // six tags over sets 0 to 3 keep evictions frequent
			addr = {24'h000040, tag_sel[2:0], 3'b000, rnd[1:0]};
			if (rnd[31])
			begin
				rnd = xorshift32(rnd);
				cpu_write(addr, rnd);
			end
			else
				read_check("random read", addr);
		end
		end_test();

		$display("%0d tests run, %0d errors", tests_run, errors + proto_errors);
		if (errors + proto_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule : tb_cache_top

`default_nettype wire
